//--- Bender.yml
package:
  name: decomp_subsystem

sources:
  # RTL, package first
  - include_dirs:
      - hw
    files:
      - hw/decomp_pkg.sv
      - hw/coef_ram.sv
      - hw/ram_arbiter.sv
      - hw/coef_reader.sv
      - hw/decomp_parallel.sv
      - hw/decomp_top.sv

  # Testbench and bound assertions
  - target: test
    include_dirs:
      - hw
    files:
      - test/decomp_chk.sv
      - test/decomp_tb.sv

//--- filelist.f
+incdir+hw
hw/decomp_pkg.sv
hw/coef_ram.sv
hw/ram_arbiter.sv
hw/coef_reader.sv
hw/decomp_parallel.sv
hw/decomp_top.sv
test/decomp_chk.sv
test/decomp_tb.sv

//--- hw/coef_ram.sv
// ----------------------------------------------------------
// Coefficient RAM
// Single-port synchronous storage, one-cycle read latency
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "decomp_cfg.svh"

module coef_ram
  import decomp_pkg::*;
(
  input  logic  clk,
  input  logic  en_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  coef_t wdata_i,
  output coef_t rdata_o
);

  // Storage array
  coef_t mem [`DECOMP_COEF_DEPTH];

  // Write port
  // Only takes effect while the port is enabled
  always_ff @(posedge clk) begin
    if (en_i && we_i) begin
      mem[addr_i] <= wdata_i;
    end
  end

  // Registered read
  // Output holds its value between reads
  always_ff @(posedge clk) begin
    if (en_i && !we_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

//--- hw/coef_reader.sv
// ----------------------------------------------------------
// Coefficient reader
// Queues host read commands, fetches the words through the
// arbiter and hands data plus tag to the decomposer
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "decomp_cfg.svh"

module coef_reader
  import decomp_pkg::*;
(
  input  logic        clk,
  input  logic        s_rst_n,
  // Host read commands
  input  logic        rd_i,
  input  addr_t       rd_addr_i,
  input  logic        rd_last_i,
  // Fetch port towards the arbiter
  output logic        fetch_req_o,
  output addr_t       fetch_addr_o,
  input  logic        fetch_gnt_i,
  input  logic        fetch_rvalid_i,
  input  coef_t       rdata_i,
  // Towards the decomposer
  output coef_t       coef_o,
  output decomp_tag_t coef_tag_o,
  output logic        coef_avail_o
);

  localparam int DEPTH = `DECOMP_CMD_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Circular command queue
  decomp_tag_t      q_mem [DEPTH];
  logic [PTR_W-1:0] q_wr_ptr;
  logic [PTR_W-1:0] q_rd_ptr;
  logic [CNT_W-1:0] q_cnt;
  logic             q_full;
  logic             q_push;
  logic             q_pop;

  // Tag of the fetch in flight
  decomp_tag_t      fetch_tag_q;

  assign q_full = (q_cnt == CNT_W'(DEPTH));
  // Host keeps within the queue depth, drop anything beyond it
  assign q_push = rd_i & ~q_full;
  // Arbiter only grants a pending request
  assign q_pop  = fetch_gnt_i;

  // Entries are payload only
  always_ff @(posedge clk) begin
    if (q_push) begin
      q_mem[q_wr_ptr] <= '{addr: rd_addr_i, last: rd_last_i};
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      q_wr_ptr <= '0;
      q_rd_ptr <= '0;
      q_cnt    <= '0;
    end else begin
      if (q_push) begin
        q_wr_ptr <= (q_wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : q_wr_ptr + 1'b1;
      end
      if (q_pop) begin
        q_rd_ptr <= (q_rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : q_rd_ptr + 1'b1;
      end
      case ({q_push, q_pop})
        2'b10:   q_cnt <= q_cnt + 1'b1;
        2'b01:   q_cnt <= q_cnt - 1'b1;
        default: q_cnt <= q_cnt;
      endcase
    end
  end

  // Request while anything is queued
  assign fetch_req_o  = (q_cnt != '0);
  assign fetch_addr_o = q_mem[q_rd_ptr].addr;

  // Hold the popped tag until its data comes back
  always_ff @(posedge clk) begin
    if (q_pop) begin
      fetch_tag_q <= q_mem[q_rd_ptr];
    end
  end

  // Data returns one cycle after grant, forward it right away
  assign coef_o       = rdata_i;
  assign coef_tag_o   = fetch_tag_q;
  assign coef_avail_o = fetch_rvalid_i;

endmodule

//--- hw/decomp_cfg.svh
// ----------------------------------------------------------
// Decomposition subsystem configuration
// Widths, depths and level count shared by package and RTL
// ----------------------------------------------------------
`ifndef DECOMP_CFG_SVH
`define DECOMP_CFG_SVH

// Torus coefficient width, arithmetic is modulo 2^OP_W
`define DECOMP_OP_W 32

// Number of decomposition levels
`define DECOMP_L 4

// Base width, digits carry one extra sign bit
`define DECOMP_B_W 4

// Coefficient RAM size
`define DECOMP_COEF_DEPTH 64
`define DECOMP_ADDR_W 6

// Entries in the reader command queue
`define DECOMP_CMD_DEPTH 4

`endif

//--- hw/decomp_parallel.sv
// ----------------------------------------------------------
// Parallel signed gadget decomposer
// Rounds a coefficient to its closest representable value
// and splits it into balanced two's complement digits
// Three-stage pipeline, side payload travels alongside
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "decomp_cfg.svh"

module decomp_parallel
  import decomp_pkg::*;
#(
  parameter type side_t = logic
) (
  input  logic      clk,
  input  logic      s_rst_n,
  input  coef_t     in_data_i,
  input  logic      in_avail_i,
  input  side_t     in_side_i,
  output subw_vec_t out_data_o,
  output logic      out_avail_o,
  output side_t     out_side_o
);

  localparam int OP_W    = `DECOMP_OP_W;
  localparam int L       = `DECOMP_L;
  localparam int B_W     = `DECOMP_B_W;
  // Bits kept by the rounding
  localparam int REP_W   = L * B_W;
  // Position of the lowest kept bit
  localparam int REP_OFS = OP_W - REP_W;

  // Input register
  coef_t s0_data;
  side_t s0_side;
  logic  s0_avail;

  always_ff @(posedge clk) begin
    s0_data <= in_data_i;
    s0_side <= in_side_i;
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s0_avail <= 1'b0;
    end else begin
      s0_avail <= in_avail_i;
    end
  end

  // Closest representable value
  // Keep the top REP_W bits, add the first discarded bit
  // All-ones top part wraps to zero, arithmetic is modulo 2^OP_W
  coef_t s0_rep;

  assign s0_rep[OP_W-1:REP_OFS] = s0_data[OP_W-1:REP_OFS] + REP_W'(s0_data[REP_OFS-1]);
  assign s0_rep[REP_OFS-1:0]    = '0;

  // Rounding register
  coef_t s1_rep;
  side_t s1_side;
  logic  s1_avail;

  always_ff @(posedge clk) begin
    s1_rep  <= s0_rep;
    s1_side <= s0_side;
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s1_avail <= 1'b0;
    end else begin
      s1_avail <= s0_avail;
    end
  end

  // Balanced digit chain, least significant digit first
  logic [B_W-1:0] s1_raw [L];
  logic [L-1:0]   s1_next_msb;
  logic [L:0]     s1_carry;
  logic [B_W:0]   s1_wc [L];
  logic [L-1:0]   s1_gt_half;
  logic [L-1:0]   s1_ge_half;
  logic [L-1:0]   s1_ovf;
  subw_vec_t      s1_subw;

  always_comb begin
    for (int i = 0; i < L; i++) begin
      s1_raw[i] = s1_rep[REP_OFS + i*B_W +: B_W];
    end
    // Next digit's MSB decides the tie at exactly half base
    // Top digit has no successor, the rounded value is read as signed
    // so its own sign extension stands in
    for (int i = 0; i < L - 1; i++) begin
      s1_next_msb[i] = s1_raw[i+1][B_W-1];
    end
    s1_next_msb[L-1] = s1_rep[OP_W-1];

    s1_carry[0] = 1'b0;
    for (int i = 0; i < L; i++) begin
      s1_wc[i] = {1'b0, s1_raw[i]} + (B_W+1)'(s1_carry[i]);
      // Look-ahead terms from raw digit and carry in, off the adder path
      // Above half base
      s1_gt_half[i] = s1_raw[i][B_W-1] & (|{s1_raw[i][B_W-2:0], s1_carry[i]});
      // At least half base
      s1_ge_half[i] = s1_raw[i][B_W-1] | (&{s1_raw[i][B_W-2:0], s1_carry[i]});
      // Sum reaches a full base
      s1_ovf[i]     = &{s1_raw[i], s1_carry[i]};
      s1_carry[i+1] = s1_ovf[i] | s1_gt_half[i] | (s1_ge_half[i] & s1_next_msb[i]);
      // Carry out means digit minus base, which flips the extra bit
      if (s1_carry[i+1]) begin
        s1_subw[i] = {~s1_wc[i][B_W], s1_wc[i][B_W-1:0]};
      end else begin
        s1_subw[i] = {1'b0, s1_wc[i][B_W-1:0]};
      end
    end
    // s1_carry[L] is dropped, modulo 2^OP_W
  end

  // Output register
  subw_vec_t s2_subw;
  side_t     s2_side;
  logic      s2_avail;

  always_ff @(posedge clk) begin
    s2_subw <= s1_subw;
    s2_side <= s1_side;
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s2_avail <= 1'b0;
    end else begin
      s2_avail <= s1_avail;
    end
  end

  assign out_data_o  = s2_subw;
  assign out_side_o  = s2_side;
  assign out_avail_o = s2_avail;

endmodule

//--- hw/decomp_pkg.sv
// ----------------------------------------------------------
// Decomposition package
// Coefficient, address, digit and tag types
// ----------------------------------------------------------
`include "decomp_cfg.svh"

package decomp_pkg;

  // Torus coefficient as stored in the RAM
  typedef logic [`DECOMP_OP_W-1:0] coef_t;

  // Coefficient RAM word address
  typedef logic [`DECOMP_ADDR_W-1:0] addr_t;

  // One balanced digit, two's complement
  // Range is [-2^(B_W-1), 2^(B_W-1)], hence B_W+1 bits
  typedef logic signed [`DECOMP_B_W:0] subw_t;

  // All digits of one coefficient
  // Index 0 holds the least significant digit
  typedef subw_t [`DECOMP_L-1:0] subw_vec_t;

  // Tag that follows a coefficient through the pipeline
  typedef struct packed {
    // Address the coefficient was read from
    addr_t addr;
    // Host marks the final read of a batch
    logic  last;
  } decomp_tag_t;

endpackage

//--- hw/decomp_top.sv
// ----------------------------------------------------------
// Decomposition subsystem top level
// Coefficient RAM shared by host writes and the reader,
// fetched words go through the signed decomposer
// ----------------------------------------------------------
`timescale 1ns/1ps

module decomp_top
  import decomp_pkg::*;
(
  input  logic      clk,
  input  logic      s_rst_n,
  // Host write
  input  logic      wr_i,
  input  addr_t     wr_addr_i,
  input  coef_t     wr_data_i,
  // Host read commands
  input  logic      rd_i,
  input  addr_t     rd_addr_i,
  input  logic      rd_last_i,
  // Decomposition results
  output subw_vec_t subw_o,
  output logic      subw_avail_o,
  output addr_t     subw_addr_o,
  output logic      subw_last_o
);

  // RAM port
  logic        ram_en;
  logic        ram_we;
  addr_t       ram_addr;
  coef_t       ram_wdata;
  coef_t       ram_rdata;

  // Reader to arbiter
  logic        fetch_req;
  addr_t       fetch_addr;
  logic        fetch_gnt;
  logic        fetch_rvalid;

  // Reader to decomposer
  coef_t       coef;
  decomp_tag_t coef_tag;
  logic        coef_avail;
  decomp_tag_t subw_tag;

  coef_ram u_ram (
    .clk     (clk),
    .en_i    (ram_en),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

  ram_arbiter u_arbiter (
    .clk            (clk),
    .s_rst_n        (s_rst_n),
    .wr_i           (wr_i),
    .wr_addr_i      (wr_addr_i),
    .wr_data_i      (wr_data_i),
    .fetch_req_i    (fetch_req),
    .fetch_addr_i   (fetch_addr),
    .fetch_gnt_o    (fetch_gnt),
    .fetch_rvalid_o (fetch_rvalid),
    .ram_en_o       (ram_en),
    .ram_we_o       (ram_we),
    .ram_addr_o     (ram_addr),
    .ram_wdata_o    (ram_wdata)
  );

  coef_reader u_reader (
    .clk            (clk),
    .s_rst_n        (s_rst_n),
    .rd_i           (rd_i),
    .rd_addr_i      (rd_addr_i),
    .rd_last_i      (rd_last_i),
    .fetch_req_o    (fetch_req),
    .fetch_addr_o   (fetch_addr),
    .fetch_gnt_i    (fetch_gnt),
    .fetch_rvalid_i (fetch_rvalid),
    .rdata_i        (ram_rdata),
    .coef_o         (coef),
    .coef_tag_o     (coef_tag),
    .coef_avail_o   (coef_avail)
  );

  // Tag rides along as the side payload
  decomp_parallel #(
    .side_t (decomp_tag_t)
  ) u_decomp (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .in_data_i   (coef),
    .in_avail_i  (coef_avail),
    .in_side_i   (coef_tag),
    .out_data_o  (subw_o),
    .out_avail_o (subw_avail_o),
    .out_side_o  (subw_tag)
  );

  assign subw_addr_o = subw_tag.addr;
  assign subw_last_o = subw_tag.last;

endmodule

//--- hw/ram_arbiter.sv
// ----------------------------------------------------------
// Coefficient RAM arbiter
// Host writes have fixed priority over reader fetches
// Produces the read-data valid one cycle after a grant
// ----------------------------------------------------------
`timescale 1ns/1ps

module ram_arbiter
  import decomp_pkg::*;
(
  input  logic  clk,
  input  logic  s_rst_n,
  // Host write port, no back-pressure
  input  logic  wr_i,
  input  addr_t wr_addr_i,
  input  coef_t wr_data_i,
  // Reader fetch port
  input  logic  fetch_req_i,
  input  addr_t fetch_addr_i,
  output logic  fetch_gnt_o,
  output logic  fetch_rvalid_o,
  // RAM side
  output logic  ram_en_o,
  output logic  ram_we_o,
  output addr_t ram_addr_o,
  output coef_t ram_wdata_o
);

  // Fetch wins only when no write is strobed this cycle
  assign fetch_gnt_o = fetch_req_i & ~wr_i;

  // RAM is busy whenever either client is active
  assign ram_en_o = wr_i | fetch_req_i;

  // Only the host ever writes
  assign ram_we_o = wr_i;

  // Address mux follows the same priority as the grant
  assign ram_addr_o = wr_i ? wr_addr_i : fetch_addr_i;

  // Write data goes straight to the RAM
  // Ignored by the RAM while we is low
  assign ram_wdata_o = wr_data_i;

  // Read data appears one cycle after the grant
  // Track the grant so the reader knows when rdata is fresh
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      fetch_rvalid_o <= 1'b0;
    end else begin
      fetch_rvalid_o <= fetch_gnt_o;
    end
  end

endmodule

//--- test/decomp_chk.sv
// ----------------------------------------------------------
// Decomposition subsystem protocol assertions
// Reader queue overflow, arbiter exclusivity and the
// fixed decomposer latency
// ----------------------------------------------------------
`timescale 1ns/1ps

module decomp_chk (
  input logic clk,
  input logic s_rst_n,
  input logic rd_i,
  input logic q_full_i,
  input logic wr_i,
  input logic fetch_req_i,
  input logic in_avail_i,
  input logic out_avail_i
);

  // Number of assertion failures so far
  int fail_cnt = 0;

  // Host never reads into a full queue
  a_rd_not_full: assert property (@(posedge clk) disable iff (!s_rst_n)
    !(rd_i && q_full_i))
    else begin
      fail_cnt++;
      $error("read command while the reader queue is full");
    end

  // Write owns the RAM in its cycle, the blocked fetch stays pending
  a_req_held_on_wr: assert property (@(posedge clk) disable iff (!s_rst_n)
    (fetch_req_i && wr_i) |=> fetch_req_i)
    else begin
      fail_cnt++;
      $error("fetch request dropped while a write held the RAM");
    end

  // Three register stages, both directions
  a_decomp_lat: assert property (@(posedge clk) disable iff (!s_rst_n)
    out_avail_i == $past(in_avail_i, 3))
    else begin
      fail_cnt++;
      $error("decomposer output strobe not 3 cycles after its input");
    end

endmodule

bind decomp_top decomp_chk u_chk (
  .clk         (clk),
  .s_rst_n     (s_rst_n),
  .rd_i        (u_reader.rd_i),
  .q_full_i    (u_reader.q_full),
  .wr_i        (u_arbiter.wr_i),
  .fetch_req_i (u_arbiter.fetch_req_i),
  .in_avail_i  (u_decomp.in_avail_i),
  .out_avail_i (u_decomp.out_avail_o)
);

//--- test/decomp_tb.sv
// ----------------------------------------------------------
// Decomposition subsystem testbench
// File-driven host writes and reads, results checked in
// command order for digits, tag, range and recombination
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "decomp_cfg.svh"

module decomp_tb
  import decomp_pkg::*;
();

  // Lowest bit kept by the rounding
  localparam int REP_OFS   = `DECOMP_OP_W - `DECOMP_L * `DECOMP_B_W;
  localparam int HALF_BASE = 1 << (`DECOMP_B_W - 1);

  // One line of the data file, fields as listed in its header
  typedef struct {
    string kind;
    int    f [7];
  } rec_t;

  // Expected result of one read, lat of 0 skips the latency check
  typedef struct {
    decomp_tag_t tag;
    subw_vec_t   subw;
    int          lat;
  } exp_t;

  logic      clk;
  logic      s_rst_n;
  logic      wr;
  addr_t     wr_addr;
  coef_t     wr_data;
  logic      rd;
  addr_t     rd_addr;
  logic      rd_last;
  subw_vec_t subw;
  logic      subw_avail;
  addr_t     subw_addr;
  logic      subw_last;

  rec_t  recs [$];
  exp_t  exp_q [$];
  // Issue cycle and rounded model value of every read, in order
  int    issue_q [$];
  coef_t round_q [$];
  // Mirror of the coefficient RAM contents
  coef_t shadow [`DECOMP_COEF_DEPTH];
  int    cyc;
  int    cycle_limit;
  bit    read_seen;

  decomp_top u_dut (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .wr_i         (wr),
    .wr_addr_i    (wr_addr),
    .wr_data_i    (wr_data),
    .rd_i         (rd),
    .rd_addr_i    (rd_addr),
    .rd_last_i    (rd_last),
    .subw_o       (subw),
    .subw_avail_o (subw_avail),
    .subw_addr_o  (subw_addr),
    .subw_last_o  (subw_last)
  );

  // 4 ns clock
  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "Run stopped");
  endtask

  // Nearest value on the kept grid, half an LSB added then truncated
  function automatic coef_t round_closest(input coef_t x);
    coef_t r;
    r = x + (coef_t'(1) << (REP_OFS - 1));
    r = (r >> REP_OFS) << REP_OFS;
    return r;
  endfunction

  // Signed digits, most significant first
  function automatic string digits_str(input subw_vec_t v);
    string s;
    s = "";
    for (int i = `DECOMP_L - 1; i >= 0; i--) begin
      s = {s, $sformatf(" %0d", v[i])};
    end
    return s;
  endfunction

  task automatic check_subw(input subw_vec_t got, input subw_vec_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: subw_o got%s expected%s",
                          $time, digits_str(got), digits_str(exp)));
    end
  endtask

  task automatic check_tag(input decomp_tag_t got, input decomp_tag_t exp);
    if (got.addr !== exp.addr) begin
      abort_run($sformatf("Error at %0t: subw_addr_o got %0d expected %0d",
                          $time, got.addr, exp.addr));
    end
    if (got.last !== exp.last) begin
      abort_run($sformatf("Error at %0t: subw_last_o got %b expected %b",
                          $time, got.last, exp.last));
    end
  endtask

  // Each digit within half a base, weighted sum equals the rounded value
  task automatic check_recombine(input subw_vec_t got, input coef_t rounded);
    coef_t acc;
    acc = '0;
    for (int i = 0; i < `DECOMP_L; i++) begin
      if (int'(got[i]) > HALF_BASE || int'(got[i]) < -HALF_BASE) begin
        abort_run($sformatf("Error at %0t: subw_o[%0d] got %0d expected within +-%0d",
                            $time, i, got[i], HALF_BASE));
      end
      acc = acc + (coef_t'(int'(got[i])) << (REP_OFS + i * `DECOMP_B_W));
    end
    if (acc !== rounded) begin
      abort_run($sformatf("Error at %0t: recombined subw_o got %h expected %h",
                          $time, acc, rounded));
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (exp != 0 && got != exp) begin
      abort_run($sformatf("Error at %0t: subw_avail_o latency got %0d expected %0d",
                          $time, got, exp));
    end
  endtask

  task automatic load_records();
    int    fd;
    int    code;
    int    want;
    string kind;
    string line;
    rec_t  r;
    fd = $fopen("test/decomp_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open test/decomp_testdata.txt");
    end
    while (!$feof(fd)) begin
      kind = "";
      code = $fscanf(fd, " %s", kind);
      if (code != 1) begin
        break;
      end
      if (kind[0] == "#") begin
        code = $fgets(line, fd);
        continue;
      end
      r.kind = kind;
      r.f    = '{default: 0};
      want   = 0;
      case (kind)
        "W": begin
          want = 3;
          code = $fscanf(fd, " %d %h %d", r.f[0], r.f[1], r.f[2]);
        end
        "R": begin
          want = 3;
          code = $fscanf(fd, " %d %d %d", r.f[0], r.f[1], r.f[2]);
        end
        "B": begin
          want = 5;
          code = $fscanf(fd, " %d %h %d %d %d", r.f[0], r.f[1], r.f[2], r.f[3], r.f[4]);
        end
        "E": begin
          want = 7;
          code = $fscanf(fd, " %d %d %d %d %d %d %d",
                         r.f[0], r.f[1], r.f[2], r.f[3], r.f[4], r.f[5], r.f[6]);
        end
        default: begin
          abort_run($sformatf("Unknown record kind %s in the test data", kind));
        end
      endcase
      if (code != want) begin
        abort_run($sformatf("Record %0d of kind %s is missing fields", recs.size(), kind));
      end
      recs.push_back(r);
    end
    $fclose(fd);
  endtask

  task automatic drive_write(input addr_t addr, input coef_t data);
    wr           = 1'b1;
    wr_addr      = addr;
    wr_data      = data;
    shadow[addr] = data;
  endtask

  // Model value is taken after any write of the same cycle
  task automatic drive_read(input addr_t addr, input logic last);
    rd        = 1'b1;
    rd_addr   = addr;
    rd_last   = last;
    read_seen = 1'b1;
    issue_q.push_back(cyc);
    round_q.push_back(round_closest(shadow[addr]));
  endtask

  task automatic apply_record(input rec_t r);
    exp_t e;
    int   gap;
    gap = 0;
    case (r.kind)
      "E": begin
        e.tag = '{addr: addr_t'(r.f[0]), last: r.f[1][0]};
        e.lat = r.f[2];
        // File lists the top digit first
        for (int i = 0; i < `DECOMP_L; i++) begin
          e.subw[i] = subw_t'(r.f[3 + `DECOMP_L - 1 - i]);
        end
        exp_q.push_back(e);
      end
      "W": begin
        drive_write(addr_t'(r.f[0]), coef_t'(r.f[1]));
        gap = r.f[2];
      end
      "R": begin
        drive_read(addr_t'(r.f[0]), r.f[1][0]);
        gap = r.f[2];
      end
      default: begin
        drive_write(addr_t'(r.f[0]), coef_t'(r.f[1]));
        drive_read(addr_t'(r.f[2]), r.f[3][0]);
        gap = r.f[4];
      end
    endcase
    // Strobes last one cycle, then the idle gap
    if (r.kind != "E") begin
      @(negedge clk);
      wr = 1'b0;
      rd = 1'b0;
      if (gap < 0) begin
        gap = $urandom_range(4, 1);
      end
      repeat (gap) @(negedge clk);
    end
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cycle_limit != 0 && cyc >= cycle_limit) begin
      abort_run($sformatf("Timeout after %0d cycles with %0d results still expected",
                          cyc, exp_q.size()));
    end
  end

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge clk) begin : result_monitor
    exp_t        e;
    decomp_tag_t got_tag;
    int          issued;
    coef_t       rounded;
    if (s_rst_n) begin
      if (u_dut.u_chk.fail_cnt != 0) begin
        abort_run("A protocol assertion in the checker failed");
      end
      if (subw_avail !== 1'b0) begin
        if (!read_seen || subw_avail !== 1'b1) begin
          abort_run($sformatf("Error at %0t: subw_avail_o got %b expected 0",
                              $time, subw_avail));
        end else if (exp_q.size() == 0) begin
          abort_run("A result strobe arrived with no expected result queued");
        end else begin
          e       = exp_q.pop_front();
          issued  = issue_q.pop_front();
          rounded = round_q.pop_front();
          got_tag = '{addr: subw_addr, last: subw_last};
          check_tag(got_tag, e.tag);
          check_recombine(subw, rounded);
          check_subw(subw, e.subw);
          check_latency(cyc - issued, e.lat);
        end
      end
    end
  end

  initial begin
    void'($urandom(23564));
    s_rst_n     = 1'b0;
    wr          = 1'b0;
    wr_addr     = '0;
    wr_data     = '0;
    rd          = 1'b0;
    rd_addr     = '0;
    rd_last     = 1'b0;
    cyc         = 0;
    cycle_limit = 0;
    read_seen   = 1'b0;
    load_records();
    cycle_limit = 20 * recs.size() + 100;
    repeat (8) @(negedge clk);
    s_rst_n = 1'b1;
    foreach (recs[i]) begin
      apply_record(recs[i]);
    end
    // Pipeline drain, then a few quiet cycles for stray strobes
    repeat (16) begin
      if (exp_q.size() == 0) begin
        break;
      end
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    if (exp_q.size() != 0) begin
      abort_run($sformatf("Run ended with %0d expected results never produced",
                          exp_q.size()));
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

//--- test/decomp_testdata.txt
# W addr data_hex gap | R addr last gap | B waddr wdata_hex raddr rlast gap (write and read at once)
# E addr last latency d3 d2 d1 d0 (latency 0 is not checked) | gap -1 gives a random idle gap
W 0 12345678 0
W 1 12348000 0
W 2 ffff8001 0
W 3 ffff7fff 0
W 4 00180000 0
W 5 00980000 0
W 6 0a791234 0
W 7 34790fff 0
W 8 9abcdef0 0
W 9 01238000 0
W 10 55550000 -1
E 0 0 5 1 2 3 4
R 0 0 -1
E 2 0 5 0 0 0 0
R 2 0 -1
E 3 0 5 0 0 0 -1
R 3 0 -1
E 5 0 5 0 1 -6 -8
R 5 0 -1
E 6 0 5 1 -5 -8 -7
R 6 0 -1
E 8 1 5 -6 -5 -4 -3
R 8 1 6
E 9 0 0 0 1 2 4
B 20 00000000 9 0 0
E 0 1 0 1 2 3 4
B 21 11111111 0 1 0
W 22 22222222 0
E 1 0 0 1 2 3 5
R 1 0 0
W 23 33333333 4
E 21 0 5 1 1 1 1
R 21 0 6
E 10 0 5 5 5 5 5
R 10 0 2
W 10 edcba987 0
E 10 1 5 -1 -2 -3 -4
R 10 1 6
E 1 0 5 1 2 3 5
R 1 0 0
E 4 0 5 0 0 1 8
R 4 0 0
E 7 0 5 3 4 8 -7
R 7 0 0
E 9 1 5 0 1 2 4
R 9 1 8
